/* src.f */
src/dcache_pkg.sv
src/dcache_array.sv
src/dcache_plru.sv
src/dcache_lookup.sv
src/dcache_miss_ctrl.sv
src/dcache_top.sv
testbench/tb_clock.sv
testbench/tb_mem_model.sv
testbench/tb_dcache.sv

/* run.sh */
#!/bin/sh
# Build with Verilator, run, and decide pass or fail from the log
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module tb_dcache \
  -f src.f -o sim_dcache \
  && ./obj_dir/sim_dcache > sim.log 2>&1 \
  || { echo "build or simulation error"; exit 1; }
cat sim.log
grep -q "SIMULATION FAILED" sim.log && exit 1 || exit 0

/* testbench/tb_dcache.sv */
// Data cache testbench
// Drives the CPU port, keeps a byte reference memory and a model of
// the tags, dirty bits and PLRU trees, and checks every access
`timescale 1ns/10ps
`default_nettype none

module tb_dcache;

  localparam int NUM_ACCESSES = 342;
  localparam int TIMEOUT_NS   = (NUM_ACCESSES * 20 + 200) * 4;
  localparam int MEM_BYTES    = 4096;

  logic         clk;
  logic         rst_n;
  logic         cpu_cyc;
  logic         cpu_stb;
  logic         cpu_we;
  logic [3:0]   cpu_sel;
  logic [31:0]  cpu_adr;
  logic [31:0]  cpu_wdat;
  logic [31:0]  cpu_rdat;
  logic         cpu_ack;
  logic         mem_cyc;
  logic         mem_stb;
  logic         mem_we;
  logic [31:0]  mem_adr;
  logic [127:0] mem_wdat;
  logic [127:0] mem_rdat;
  logic         mem_ack;

  // Reference byte memory and cache model
  logic [7:0]   ref_mem [MEM_BYTES];
  logic [31:0]  mdl_line [8][4];
  logic         mdl_valid [8][4];
  logic         mdl_dirty [8][4];
  logic [2:0]   tree [8];
  int           errors;
  int           errors_at_start;
  int           tests_passed;
  int           tests_failed;
  integer       seed;

  tb_clock #(.PERIOD_NS(4), .RST_CYCLES(2)) clk0 (.clk_o(clk), .rst_no(rst_n));

  tb_mem_model #(.LINE_BITS(128), .MEM_BYTES(MEM_BYTES)) mem0 (
    .clk_i (clk), .cyc_i (mem_cyc), .stb_i (mem_stb), .we_i (mem_we),
    .adr_i (mem_adr), .dat_i (mem_wdat), .dat_o (mem_rdat), .ack_o (mem_ack)
  );

  dcache_top dut0 (
    .clk_i     (clk),
    .rst_ni    (rst_n),
    .cpu_cyc_i (cpu_cyc),
    .cpu_stb_i (cpu_stb),
    .cpu_we_i  (cpu_we),
    .cpu_sel_i (cpu_sel),
    .cpu_adr_i (cpu_adr),
    .cpu_dat_i (cpu_wdat),
    .cpu_dat_o (cpu_rdat),
    .cpu_ack_o (cpu_ack),
    .mem_cyc_o (mem_cyc),
    .mem_stb_o (mem_stb),
    .mem_we_o  (mem_we),
    .mem_adr_o (mem_adr),
    .mem_dat_o (mem_wdat),
    .mem_dat_i (mem_rdat),
    .mem_ack_i (mem_ack)
  );

  // ====================
  // Helpers
  // ====================
  function automatic logic [7:0] start_byte(input logic [31:0] a);
    return (a[7:0] + (a[15:8] * 8'd3)) ^ a[23:16] ^ a[31:24] ^ 8'h3c;
  endfunction

  // Tree PLRU with node 0 as root and children 2n+1 and 2n+2
  // A node bit of 0 points left
  function automatic logic [2:0] plru_touch(input logic [2:0] t, input int way);
    logic [2:0] r;
    int         node;
    int         dir;
    r    = t;
    node = 0;
    for (int l = 1; l >= 0; l--) begin
      dir     = (way >> l) & 1;
      r[node] = (dir == 0);
      node    = 2 * node + 1 + dir;
    end
    return r;
  endfunction

  function automatic int plru_victim(input logic [2:0] t);
    int node;
    int v;
    node = 0;
    v    = 0;
    for (int l = 0; l < 2; l++) begin
      v    = 2 * v + int'(t[node]);
      node = 2 * node + 1 + int'(t[node]);
    end
    return v;
  endfunction

  task automatic check_val(input string name, input logic [127:0] exp, input logic [127:0] act);
    assert (act === exp) else begin
      $display("FAILED at %0t ns: %s expected %h actual %h", $time, name, exp, act);
      errors++;
    end
  endtask

  task automatic check_true(input logic cond, input string what);
    assert (cond) else begin
      $display("Error at %0t ns: %s", $time, what);
      errors++;
    end
  endtask

  task automatic finish_test(input string name);
    if (errors == errors_at_start) begin
      tests_passed++;
      $display("test %s: pass", name);
    end else begin
      tests_failed++;
      $display("test %s: fail with %0d errors", name, errors - errors_at_start);
    end
    errors_at_start = errors;
  endtask

  // One CPU access checked against the reference and the cache model
  task automatic cpu_access(input logic we, input logic [3:0] sel,
                            input logic [31:0] adr, input logic [31:0] wdat);
    int           set;
    int           way;
    int           hit_w;
    int           rd0;
    int           wr0;
    int           n;
    int           a;
    logic         saw_mem;
    logic         exp_wb;
    logic [31:0]  vic_adr;
    logic [31:0]  exp_word;
    logic [127:0] exp_line;
    set   = int'(adr[6:4]);
    hit_w = -1;
    for (int w = 0; w < 4; w++) begin
      if (mdl_valid[set][w] && mdl_line[set][w] == (adr & ~32'hf)) begin
        hit_w = w;
      end
    end
    // Hit way or the PLRU victim on a miss
    way     = (hit_w >= 0) ? hit_w : plru_victim(tree[set]);
    exp_wb  = (hit_w < 0) && mdl_valid[set][way] && mdl_dirty[set][way];
    vic_adr = mdl_line[set][way];
    for (int o = 0; o < 16; o++) begin
      exp_line[o*8 +: 8] = ref_mem[(int'(vic_adr) + o) % MEM_BYTES];
    end
    a        = int'(adr[11:0]) & ~3;
    exp_word = {ref_mem[a+3], ref_mem[a+2], ref_mem[a+1], ref_mem[a]};
    rd0      = mem0.rd_count;
    wr0      = mem0.wr_count;
    cpu_cyc  = 1'b1;
    cpu_stb  = 1'b1;
    cpu_we   = we;
    cpu_sel  = sel;
    cpu_adr  = adr;
    cpu_wdat = wdat;
    n        = 0;
    saw_mem  = 1'b0;
    do begin
      @(posedge clk);
      #1;
      n++;
      if (mem_cyc) begin
        saw_mem = 1'b1;
      end
    end while (cpu_ack !== 1'b1);
    if (!we) begin
      check_val("cpu_dat_o", 128'(exp_word), 128'(cpu_rdat));
    end
    if (hit_w >= 0) begin
      check_val("hit ack latency", 128'(2), 128'(n));
      check_true(!saw_mem, "memory transaction during a hit");
    end else begin
      check_true(saw_mem, "miss acked without a memory transaction");
      check_val("fill read count", 128'(rd0 + 1), 128'(mem0.rd_count));
    end
    check_val("writeback count", 128'(wr0 + int'(exp_wb)), 128'(mem0.wr_count));
    if (exp_wb && mem0.wr_count > wr0) begin
      check_val("writeback mem_adr_o", 128'(vic_adr), 128'(mem0.wb_adr_q[mem0.wr_count-1]));
      check_val("writeback mem_dat_o", exp_line, mem0.wb_line_q[mem0.wr_count-1]);
    end
    // Reference and model follow the completed access
    if (we) begin
      for (int b = 0; b < 4; b++) begin
        if (sel[b]) begin
          ref_mem[a+b] = wdat[b*8 +: 8];
        end
      end
    end
    if (hit_w < 0) begin
      mdl_line[set][way]  = adr & ~32'hf;
      mdl_valid[set][way] = 1'b1;
      mdl_dirty[set][way] = 1'b0;
    end
    if (we) begin
      mdl_dirty[set][way] = 1'b1;
    end
    tree[set] = plru_touch(tree[set], way);
    @(posedge clk);
    #1;
    cpu_cyc = 1'b0;
    cpu_stb = 1'b0;
    cpu_we  = 1'b0;
  endtask

  // ====================
  // Memory bus strobe
  // ====================
  // Strobe rises and falls together with the cycle signal
  always @(negedge clk) begin
    check_true(mem_stb === mem_cyc, "mem_stb_o does not follow mem_cyc_o");
  end

  // ====================
  // Watchdog
  // ====================
  initial begin
    #(TIMEOUT_NS);
    $display("Timeout: the cache stopped answering before the tests ended");
    $display("SIMULATION FAILED");
    $finish;
  end

  // ====================
  // Stimulus
  // ====================
  initial begin
    logic [31:0] r;
    logic [31:0] adr;
    logic [3:0]  sel;
    int          wr0;
    cpu_cyc         = 1'b0;
    cpu_stb         = 1'b0;
    cpu_we          = 1'b0;
    cpu_sel         = 4'h0;
    cpu_adr         = '0;
    cpu_wdat        = '0;
    errors          = 0;
    errors_at_start = 0;
    tests_passed    = 0;
    tests_failed    = 0;
    seed            = 32'h1480;
    for (int a = 0; a < MEM_BYTES; a++) begin
      ref_mem[a] = start_byte(32'(a));
    end
    for (int s = 0; s < 8; s++) begin
      tree[s] = '0;
      for (int w = 0; w < 4; w++) begin
        mdl_line[s][w]  = '0;
        mdl_valid[s][w] = 1'b0;
        mdl_dirty[s][w] = 1'b0;
      end
    end
    wait (rst_n === 1'b1);

    // First touches of two lines miss
    cpu_access(1'b0, 4'hf, 32'h000, 32'h0);
    cpu_access(1'b0, 4'hf, 32'h094, 32'h0);
    finish_test("first access miss");

    // Same lines again hit in 2 cycles
    cpu_access(1'b0, 4'hf, 32'h004, 32'h0);
    cpu_access(1'b0, 4'hf, 32'h008, 32'h0);
    cpu_access(1'b0, 4'hf, 32'h09c, 32'h0);
    finish_test("hit latency");

    // Byte and half-word stores followed by reads
    cpu_access(1'b1, 4'b0001, 32'h120, 32'h000000a5);
    cpu_access(1'b1, 4'b0100, 32'h124, 32'h00c30000);
    cpu_access(1'b1, 4'b1100, 32'h128, 32'hbeef0000);
    cpu_access(1'b1, 4'b0011, 32'h12c, 32'h00001234);
    cpu_access(1'b1, 4'b0010, 32'h134, 32'h00007700);
    cpu_access(1'b0, 4'hf, 32'h120, 32'h0);
    cpu_access(1'b0, 4'hf, 32'h124, 32'h0);
    cpu_access(1'b0, 4'hf, 32'h128, 32'h0);
    cpu_access(1'b0, 4'hf, 32'h12c, 32'h0);
    cpu_access(1'b0, 4'hf, 32'h134, 32'h0);
    finish_test("sub-word stores");

    // Five dirty lines in set 6 where the fifth evicts the PLRU victim
    wr0 = mem0.wr_count;
    for (int t = 0; t < 5; t++) begin
      cpu_access(1'b1, 4'hf, 32'(t * 128 + 96), 32'hd00d0000 + 32'(t));
    end
    check_true(mem0.wr_count > wr0, "no writeback on the fifth dirty line");
    cpu_access(1'b0, 4'hf, 32'(96), 32'h0);
    finish_test("dirty writeback");

    // Five clean lines in set 7 cause no write
    wr0 = mem0.wr_count;
    for (int t = 0; t < 5; t++) begin
      cpu_access(1'b0, 4'hf, 32'(t * 128 + 112), 32'h0);
    end
    check_true(mem0.wr_count == wr0, "write transaction on a clean eviction");
    finish_test("clean eviction");

    // Random reads and writes over sets 0 to 3 and 16 tags
    for (int i = 0; i < 300; i++) begin
      r   = $random(seed);
      adr = {21'd0, r[6:3], 1'b0, r[2:1], r[8:7], 2'b00};
      sel = (r[12:9] == 4'h0) ? 4'hf : r[12:9];
      cpu_access(r[0], sel, adr, $random(seed));
    end
    // Conflicting reads push every dirty line out
    for (int s = 0; s < 4; s++) begin
      for (int t = 16; t < 20; t++) begin
        cpu_access(1'b0, 4'hf, 32'(t * 128 + s * 16), 32'h0);
      end
    end
    for (int a = 0; a < 2048; a++) begin
      if (((a >> 4) & 7) < 4) begin
        check_val($sformatf("memory byte %0h", a), 128'(ref_mem[a]), 128'(mem0.mem[a]));
      end
    end
    finish_test("random mix");

    $display("tests passed %0d failed %0d", tests_passed, tests_failed);
    if (tests_failed == 0 && errors == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* testbench/tb_mem_model.sv */
// Line-wide Wishbone slave memory for the testbench
// Acks each request after 1 to 4 cycles and logs every write
`timescale 1ns/10ps
`default_nettype none

module tb_mem_model #(
  parameter int LINE_BITS = 128,
  parameter int MEM_BYTES = 4096
) (
  input  logic                 clk_i,
  input  logic                 cyc_i,
  input  logic                 stb_i,
  input  logic                 we_i,
  input  logic [31:0]          adr_i,
  input  logic [LINE_BITS-1:0] dat_i,
  output logic [LINE_BITS-1:0] dat_o,
  output logic                 ack_o
);

  localparam int LINE_BYTES = LINE_BITS / 8;

  logic [7:0]           mem [MEM_BYTES];
  // Writeback log, one entry per write transaction
  logic [31:0]          wb_adr_q [$];
  logic [LINE_BITS-1:0] wb_line_q [$];
  int                   rd_count;
  int                   wr_count;
  integer               seed;
  int                   wait_cnt;
  int                   base;

  // Start-up contents, every address bit contributes
  function automatic logic [7:0] init_byte(input logic [31:0] a);
    return (a[7:0] + (a[15:8] * 8'd3)) ^ a[23:16] ^ a[31:24] ^ 8'h3c;
  endfunction

  initial begin
    seed     = 32'h1480;
    ack_o    = 1'b0;
    dat_o    = '0;
    rd_count = 0;
    wr_count = 0;
    for (int a = 0; a < MEM_BYTES; a++) begin
      mem[a] = init_byte(32'(a));
    end
    wait_cnt = int'($unsigned($random(seed)) % 4);
  end

  // ====================
  // Bus response
  // ====================
  // Acts 1 ns after the edge, ack is a single-cycle pulse
  always begin
    @(posedge clk_i);
    #1;
    if (ack_o) begin
      ack_o = 1'b0;
    end else if (cyc_i && stb_i) begin
      if (wait_cnt == 0) begin
        // Line-aligned, folded into the modelled range
        base = int'(adr_i) & ~(LINE_BYTES - 1) & (MEM_BYTES - 1);
        if (we_i) begin
          for (int o = 0; o < LINE_BYTES; o++) begin
            mem[base + o] = dat_i[o*8 +: 8];
          end
          wb_adr_q.push_back(adr_i);
          wb_line_q.push_back(dat_i);
          wr_count++;
        end else begin
          for (int o = 0; o < LINE_BYTES; o++) begin
            dat_o[o*8 +: 8] = mem[base + o];
          end
          rd_count++;
        end
        ack_o    = 1'b1;
        wait_cnt = int'($unsigned($random(seed)) % 4);
      end else begin
        wait_cnt--;
      end
    end
  end

endmodule

`default_nettype wire

/* testbench/tb_clock.sv */
// Testbench clock and reset generator
// Free-running clock and an active-low reset held for a few cycles
`timescale 1ns/10ps
`default_nettype none

module tb_clock #(
  parameter int PERIOD_NS  = 4,
  parameter int RST_CYCLES = 2
) (
  output logic clk_o,
  output logic rst_no
);

  // Clock starts low, half period per phase
  initial begin
    clk_o = 1'b0;
    forever #(PERIOD_NS / 2) clk_o = ~clk_o;
  end

  // Release reset just after a rising edge, like every other input
  initial begin
    rst_no = 1'b0;
    repeat (RST_CYCLES) @(posedge clk_o);
    #1;
    rst_no = 1'b1;
  end

endmodule

`default_nettype wire

/* src/dcache_top.sv */
// Data cache top level
// Write-back, set-associative cache with tree PLRU replacement.
// Wishbone classic slave towards the CPU, line-wide master to memory.
`timescale 1ns/10ps
`default_nettype none

module dcache_top #(
  parameter int LINE_BITS = dcache_pkg::DEF_LINE_BITS,
  parameter int NUM_WAYS  = dcache_pkg::DEF_NUM_WAYS,
  parameter int NUM_SETS  = dcache_pkg::DEF_NUM_SETS
) (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  // CPU port
  input  logic                 cpu_cyc_i,
  input  logic                 cpu_stb_i,
  input  logic                 cpu_we_i,
  input  dcache_pkg::sel_t     cpu_sel_i,
  input  dcache_pkg::addr_t    cpu_adr_i,
  input  dcache_pkg::word_t    cpu_dat_i,
  output dcache_pkg::word_t    cpu_dat_o,
  output logic                 cpu_ack_o,
  // Memory port, whole lines
  output logic                 mem_cyc_o,
  output logic                 mem_stb_o,
  output logic                 mem_we_o,
  output dcache_pkg::addr_t    mem_adr_o,
  output logic [LINE_BITS-1:0] mem_dat_o,
  input  logic [LINE_BITS-1:0] mem_dat_i,
  input  logic                 mem_ack_i
);

  localparam int OFF_W = $clog2(LINE_BITS / 8);
  localparam int IDX_W = $clog2(NUM_SETS);
  localparam int TAG_W = dcache_pkg::ADDR_W - IDX_W - OFF_W;

  logic [IDX_W-1:0]                   arr_idx;
  logic [NUM_WAYS-1:0]                tag_we;
  logic [NUM_WAYS-1:0]                line_we;
  logic [TAG_W:0]                     tag_wdata;
  logic [NUM_WAYS-1:0][TAG_W:0]       tag_rd;
  logic [NUM_WAYS-1:0][LINE_BITS-1:0] line_rd;
  logic [LINE_BITS-1:0]               wr_line;
  logic [LINE_BITS-1:0]               victim_line;
  logic [NUM_WAYS-1:0]                hit_way;
  logic [NUM_WAYS-1:0]                victim_way;
  dcache_pkg::addr_t                  victim_adr;
  logic                               hit;
  logic                               victim_dirty;
  logic                               fill_sel;
  logic                               touch;
  logic                               dirty_set;
  logic                               dirty_clear;

  // ====================
  // Storage, one tag and one line array per way
  // ====================
  for (genvar w = 0; w < NUM_WAYS; w++) begin : g_way
    // Valid flag plus tag
    dcache_array #(
      .entry_t (logic [TAG_W:0]),
      .DEPTH   (NUM_SETS)
    ) u_tag (
      .clk_i   (clk_i),
      .idx_i   (arr_idx),
      .we_i    (tag_we[w]),
      .wdata_i (tag_wdata),
      .rdata_o (tag_rd[w])
    );

    dcache_array #(
      .entry_t (logic [LINE_BITS-1:0]),
      .DEPTH   (NUM_SETS)
    ) u_line (
      .clk_i   (clk_i),
      .idx_i   (arr_idx),
      .we_i    (line_we[w]),
      .wdata_i (wr_line),
      .rdata_o (line_rd[w])
    );
  end

  dcache_plru #(
    .NUM_WAYS     (NUM_WAYS),
    .NUM_SETS     (NUM_SETS)
  ) u_plru (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .idx_i        (arr_idx),
    .touch_i      (touch),
    .touch_way_i  (hit_way),
    .victim_way_o (victim_way)
  );

  dcache_lookup #(
    .LINE_BITS      (LINE_BITS),
    .NUM_WAYS       (NUM_WAYS),
    .NUM_SETS       (NUM_SETS)
  ) u_lookup (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .adr_i          (cpu_adr_i),
    .we_i           (cpu_we_i),
    .sel_i          (cpu_sel_i),
    .dat_i          (cpu_dat_i),
    .tag_rd_i       (tag_rd),
    .line_rd_i      (line_rd),
    .fill_line_i    (mem_dat_i),
    .fill_sel_i     (fill_sel),
    .victim_way_i   (victim_way),
    .dirty_set_i    (dirty_set),
    .dirty_clear_i  (dirty_clear),
    .hit_o          (hit),
    .hit_way_o      (hit_way),
    .victim_dirty_o (victim_dirty),
    .victim_adr_o   (victim_adr),
    .victim_line_o  (victim_line),
    .wr_line_o      (wr_line),
    .dat_o          (cpu_dat_o)
  );

  dcache_miss_ctrl #(
    .LINE_BITS      (LINE_BITS),
    .NUM_WAYS       (NUM_WAYS),
    .NUM_SETS       (NUM_SETS)
  ) u_ctrl (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .cpu_cyc_i      (cpu_cyc_i),
    .cpu_stb_i      (cpu_stb_i),
    .cpu_we_i       (cpu_we_i),
    .cpu_adr_i      (cpu_adr_i),
    .cpu_ack_o      (cpu_ack_o),
    .hit_i          (hit),
    .hit_way_i      (hit_way),
    .victim_way_i   (victim_way),
    .victim_dirty_i (victim_dirty),
    .victim_adr_i   (victim_adr),
    .victim_line_i  (victim_line),
    .mem_cyc_o      (mem_cyc_o),
    .mem_stb_o      (mem_stb_o),
    .mem_we_o       (mem_we_o),
    .mem_adr_o      (mem_adr_o),
    .mem_dat_o      (mem_dat_o),
    .mem_ack_i      (mem_ack_i),
    .arr_idx_o      (arr_idx),
    .tag_we_o       (tag_we),
    .line_we_o      (line_we),
    .tag_wdata_o    (tag_wdata),
    .fill_sel_o     (fill_sel),
    .touch_o        (touch),
    .dirty_set_o    (dirty_set),
    .dirty_clear_o  (dirty_clear)
  );

endmodule

`default_nettype wire

/* src/dcache_miss_ctrl.sv */
// Data cache controller
// Runs the invalidation sweep after reset, then serves one CPU access
// at a time: lookup, optional writeback of a dirty victim, line fill.
// Master on the line-wide memory Wishbone port.
`timescale 1ns/10ps
`default_nettype none

module dcache_miss_ctrl #(
  parameter int  LINE_BITS = dcache_pkg::DEF_LINE_BITS,
  parameter int  NUM_WAYS  = dcache_pkg::DEF_NUM_WAYS,
  parameter int  NUM_SETS  = dcache_pkg::DEF_NUM_SETS,
  localparam int OFF_W     = $clog2(LINE_BITS / 8),
  localparam int IDX_W     = $clog2(NUM_SETS),
  localparam int TAG_W     = dcache_pkg::ADDR_W - IDX_W - OFF_W
) (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  logic                 cpu_cyc_i,
  input  logic                 cpu_stb_i,
  input  logic                 cpu_we_i,
  input  dcache_pkg::addr_t    cpu_adr_i,
  output logic                 cpu_ack_o,
  input  logic                 hit_i,
  input  logic [NUM_WAYS-1:0]  hit_way_i,
  input  logic [NUM_WAYS-1:0]  victim_way_i,
  input  logic                 victim_dirty_i,
  input  dcache_pkg::addr_t    victim_adr_i,
  input  logic [LINE_BITS-1:0] victim_line_i,
  output logic                 mem_cyc_o,
  output logic                 mem_stb_o,
  output logic                 mem_we_o,
  output dcache_pkg::addr_t    mem_adr_o,
  output logic [LINE_BITS-1:0] mem_dat_o,
  input  logic                 mem_ack_i,
  output logic [IDX_W-1:0]     arr_idx_o,
  output logic [NUM_WAYS-1:0]  tag_we_o,
  output logic [NUM_WAYS-1:0]  line_we_o,
  output logic [TAG_W:0]       tag_wdata_o,
  output logic                 fill_sel_o,
  output logic                 touch_o,
  output logic                 dirty_set_o,
  output logic                 dirty_clear_o
);

  typedef enum logic [2:0] {
    ST_SWEEP,
    ST_IDLE,
    ST_LOOKUP,
    ST_WRITEBACK,
    ST_FILL,
    ST_RESPOND
  } state_t;

  state_t           state_q;
  state_t           state_d;
  logic             mem_req_q;
  logic             mem_req_d;
  logic [IDX_W-1:0] sweep_q;
  logic [IDX_W-1:0] idx_q;
  logic             hit_done;
  logic             fill_done;

  // Lookup hit completes the access in this cycle
  assign hit_done  = (state_q == ST_LOOKUP) && hit_i;
  // Fill line arrives on the memory ack
  assign fill_done = (state_q == ST_FILL) && mem_req_q && mem_ack_i;

  // ====================
  // Next state
  // ====================
  always_comb begin
    state_d   = state_q;
    mem_req_d = mem_req_q;
    case (state_q)
      ST_SWEEP: begin
        if (sweep_q == IDX_W'(NUM_SETS - 1)) begin
          state_d = ST_IDLE;
        end
      end
      ST_IDLE: begin
        if (cpu_cyc_i && cpu_stb_i) begin
          state_d = ST_LOOKUP;
        end
      end
      ST_LOOKUP: begin
        if (hit_i) begin
          state_d = ST_RESPOND;
        end else begin
          // Miss, a dirty victim goes out before the fill
          mem_req_d = 1'b1;
          state_d   = victim_dirty_i ? ST_WRITEBACK : ST_FILL;
        end
      end
      ST_WRITEBACK: begin
        if (mem_ack_i) begin
          mem_req_d = 1'b0;
          state_d   = ST_FILL;
        end
      end
      ST_FILL: begin
        if (!mem_req_q) begin
          // Idle cycle between writeback and fill, then request
          mem_req_d = 1'b1;
        end else if (mem_ack_i) begin
          mem_req_d = 1'b0;
          // Re-lookup hits the filled way and finishes like a hit
          state_d   = ST_LOOKUP;
        end
      end
      ST_RESPOND: begin
        state_d = ST_IDLE;
      end
      default: begin
        state_d = ST_IDLE;
      end
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      state_q   <= ST_SWEEP;
      mem_req_q <= 1'b0;
      sweep_q   <= '0;
    end else begin
      state_q   <= state_d;
      mem_req_q <= mem_req_d;
      if (state_q == ST_SWEEP) begin
        sweep_q <= sweep_q + 1'b1;
      end
    end
  end

  // Request set index, held from idle until the ack
  always_ff @(posedge clk_i) begin
    if (state_q == ST_IDLE) begin
      idx_q <= cpu_adr_i[OFF_W +: IDX_W];
    end
  end

  // ====================
  // Array control
  // ====================
  // Idle reads straight from the CPU address so the hit path saves a cycle
  always_comb begin
    case (state_q)
      ST_SWEEP: arr_idx_o = sweep_q;
      ST_IDLE:  arr_idx_o = cpu_adr_i[OFF_W +: IDX_W];
      default:  arr_idx_o = idx_q;
    endcase
  end

  // Sweep clears valid in all ways, a fill installs the new tag
  assign tag_we_o    = (state_q == ST_SWEEP) ? '1 : (fill_done ? victim_way_i : '0);
  assign tag_wdata_o = (state_q == ST_SWEEP) ? '0
                     : {1'b1, cpu_adr_i[dcache_pkg::ADDR_W-1 -: TAG_W]};

  always_comb begin
    line_we_o = '0;
    if (fill_done) begin
      line_we_o = victim_way_i;
    end else if (hit_done && cpu_we_i) begin
      line_we_o = hit_way_i;
    end
  end

  assign fill_sel_o    = (state_q == ST_FILL);
  assign touch_o       = hit_done;
  assign dirty_set_o   = hit_done && cpu_we_i;
  assign dirty_clear_o = fill_done;

  // ====================
  // Bus outputs
  // ====================
  assign cpu_ack_o = (state_q == ST_RESPOND);

  assign mem_cyc_o = mem_req_q;
  assign mem_stb_o = mem_req_q;
  assign mem_we_o  = (state_q == ST_WRITEBACK);
  // Writeback goes to the victim line, fill reads the request line
  assign mem_adr_o = (state_q == ST_WRITEBACK) ? victim_adr_i
                   : {cpu_adr_i[dcache_pkg::ADDR_W-1:OFF_W], {OFF_W{1'b0}}};
  assign mem_dat_o = victim_line_i;

endmodule

`default_nettype wire

/* src/dcache_lookup.sv */
// Data cache hit lookup and store merge
// Compares the stored tags, selects the hit or fill line, returns the
// addressed word and merges store bytes. Also keeps the dirty bits.
`timescale 1ns/10ps
`default_nettype none

module dcache_lookup #(
  parameter int  LINE_BITS = dcache_pkg::DEF_LINE_BITS,
  parameter int  NUM_WAYS  = dcache_pkg::DEF_NUM_WAYS,
  parameter int  NUM_SETS  = dcache_pkg::DEF_NUM_SETS,
  localparam int OFF_W     = $clog2(LINE_BITS / 8),
  localparam int IDX_W     = $clog2(NUM_SETS),
  localparam int TAG_W     = dcache_pkg::ADDR_W - IDX_W - OFF_W
) (
  input  logic                                clk_i,
  input  logic                                rst_ni,
  input  dcache_pkg::addr_t                   adr_i,
  input  logic                                we_i,
  input  dcache_pkg::sel_t                    sel_i,
  input  dcache_pkg::word_t                   dat_i,
  input  logic [NUM_WAYS-1:0][TAG_W:0]        tag_rd_i,
  input  logic [NUM_WAYS-1:0][LINE_BITS-1:0]  line_rd_i,
  input  logic [LINE_BITS-1:0]                fill_line_i,
  input  logic                                fill_sel_i,
  input  logic [NUM_WAYS-1:0]                 victim_way_i,
  input  logic                                dirty_set_i,
  input  logic                                dirty_clear_i,
  output logic                                hit_o,
  output logic [NUM_WAYS-1:0]                 hit_way_o,
  output logic                                victim_dirty_o,
  output dcache_pkg::addr_t                   victim_adr_o,
  output logic [LINE_BITS-1:0]                victim_line_o,
  output logic [LINE_BITS-1:0]                wr_line_o,
  output dcache_pkg::word_t                   dat_o
);

  // Address fields: | tag | index | word | byte |
  logic [IDX_W-1:0]     idx;
  logic [TAG_W-1:0]     req_tag;
  logic [OFF_W-3:0]     word_idx;
  logic [NUM_WAYS-1:0]  valid;
  logic [NUM_WAYS-1:0]  hit_way;
  logic [LINE_BITS-1:0] hit_line;
  logic [LINE_BITS-1:0] base_line;
  logic [TAG_W-1:0]     victim_tag;
  logic [NUM_WAYS-1:0]  dirty_q [NUM_SETS];

  assign idx      = adr_i[OFF_W +: IDX_W];
  assign req_tag  = adr_i[dcache_pkg::ADDR_W-1 -: TAG_W];
  assign word_idx = adr_i[OFF_W-1:2];

  // ====================
  // Tag compare
  // ====================
  always_comb begin
    hit_line      = '0;
    victim_tag    = '0;
    victim_line_o = '0;
    for (int w = 0; w < NUM_WAYS; w++) begin
      // Top bit of a tag entry is the valid flag
      valid[w]   = tag_rd_i[w][TAG_W];
      hit_way[w] = valid[w] && (tag_rd_i[w][TAG_W-1:0] == req_tag);
      if (hit_way[w]) begin
        hit_line = line_rd_i[w];
      end
      if (victim_way_i[w]) begin
        victim_tag    = tag_rd_i[w][TAG_W-1:0];
        victim_line_o = line_rd_i[w];
      end
    end
  end

  assign hit_o     = |hit_way;
  assign hit_way_o = hit_way;

  // Victim needs a writeback only when it holds modified data
  assign victim_dirty_o = |(victim_way_i & valid & dirty_q[idx]);
  // Victim line address from its stored tag and this set
  assign victim_adr_o   = {victim_tag, idx, {OFF_W{1'b0}}};

  // ====================
  // Read word and store merge
  // ====================
  // Memory data bypasses the arrays while a fill is in flight
  assign base_line = fill_sel_i ? fill_line_i : hit_line;
  assign dat_o     = base_line[word_idx*dcache_pkg::WORD_W +: dcache_pkg::WORD_W];

  always_comb begin
    wr_line_o = base_line;
    if (we_i) begin
      // Replace only the enabled byte lanes of the addressed word
      for (int b = 0; b < dcache_pkg::SEL_W; b++) begin
        if (sel_i[b]) begin
          wr_line_o[word_idx*dcache_pkg::WORD_W + b*8 +: 8] = dat_i[b*8 +: 8];
        end
      end
    end
  end

  // Dirty bits: set by a store that completes, cleared by a fill
  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      for (int s = 0; s < NUM_SETS; s++) begin
        dirty_q[s] <= '0;
      end
    end else if (dirty_set_i) begin
      dirty_q[idx] <= dirty_q[idx] | hit_way;
    end else if (dirty_clear_i) begin
      dirty_q[idx] <= dirty_q[idx] & ~victim_way_i;
    end
  end

endmodule

`default_nettype wire

/* src/dcache_plru.sv */
// Data cache tree pseudo-LRU
// Holds NUM_WAYS-1 tree bits per set. A touch points every node on the
// path away from the touched way; the victim is found by following them.
`timescale 1ns/10ps
`default_nettype none

module dcache_plru #(
  parameter int  NUM_WAYS = dcache_pkg::DEF_NUM_WAYS,
  parameter int  NUM_SETS = dcache_pkg::DEF_NUM_SETS,
  localparam int IDX_W    = $clog2(NUM_SETS),
  localparam int LVL      = $clog2(NUM_WAYS)
) (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  logic [IDX_W-1:0]    idx_i,
  input  logic                touch_i,
  input  logic [NUM_WAYS-1:0] touch_way_i,
  output logic [NUM_WAYS-1:0] victim_way_o
);

  // Heap layout: node 0 is the root, children of n are 2n+1 and 2n+2
  // Bit value 0 means the victim lies on the left, 1 on the right
  logic [NUM_WAYS-2:0] tree_q [NUM_SETS];
  logic [NUM_WAYS-2:0] tree_cur;
  logic [NUM_WAYS-2:0] tree_next;
  logic                upd_dir;
  logic                vic_dir;
  int unsigned         touch_idx;
  int unsigned         upd_node;
  int unsigned         vic_node;
  int unsigned         vic_idx;

  assign tree_cur = tree_q[idx_i];

  // ====================
  // Update on touch
  // ====================
  always_comb begin
    // One-hot way to index
    touch_idx = 0;
    for (int unsigned w = 0; w < NUM_WAYS; w++) begin
      if (touch_way_i[w]) begin
        touch_idx = w;
      end
    end
    tree_next = tree_cur;
    upd_node  = 0;
    // Walk root to leaf, MSB of the way index picks the first branch
    for (int unsigned l = 0; l < LVL; l++) begin
      upd_dir             = 1'((touch_idx >> (LVL - 1 - l)) & 1);
      tree_next[upd_node] = ~upd_dir;
      upd_node            = 2 * upd_node + 1 + 32'(upd_dir);
    end
  end

  // ====================
  // Victim choice
  // ====================
  always_comb begin
    vic_node = 0;
    vic_idx  = 0;
    // Follow the node bits, all zero leads to way 0
    for (int unsigned l = 0; l < LVL; l++) begin
      vic_dir  = tree_cur[vic_node];
      vic_idx  = 2 * vic_idx + 32'(vic_dir);
      vic_node = 2 * vic_node + 1 + 32'(vic_dir);
    end
    victim_way_o = NUM_WAYS'(1) << vic_idx;
  end

  // Tree registers, one word per set
  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      for (int s = 0; s < NUM_SETS; s++) begin
        tree_q[s] <= '0;
      end
    end else if (touch_i) begin
      tree_q[idx_i] <= tree_next;
    end
  end

endmodule

`default_nettype wire

/* src/dcache_array.sv */
// Data cache storage array
// Single-port RAM with synchronous read, one entry per set.
// Entry type is a parameter so tags and lines share this block.
`timescale 1ns/10ps
`default_nettype none

module dcache_array #(
  parameter type entry_t = logic,
  parameter int  DEPTH   = dcache_pkg::DEF_NUM_SETS,
  localparam int IDX_W   = $clog2(DEPTH)
) (
  input  logic             clk_i,
  input  logic [IDX_W-1:0] idx_i,
  input  logic             we_i,
  input  entry_t           wdata_i,
  output entry_t           rdata_o
);

  // Storage, contents undefined until written
  entry_t mem_q [DEPTH];

  // Write-first port: a write shows up on rdata_o in the next cycle,
  // which lets the controller re-read a freshly filled way at once
  always_ff @(posedge clk_i) begin
    if (we_i) begin
      mem_q[idx_i] <= wdata_i;
      rdata_o      <= wdata_i;
    end else begin
      rdata_o <= mem_q[idx_i];
    end
  end

endmodule

`default_nettype wire

/* src/dcache_pkg.sv */
// Data cache shared definitions
// Bus widths, the CPU-side types and the default cache geometry
`default_nettype none

package dcache_pkg;

  // ====================
  // CPU bus widths
  // ====================

  // Byte address width
  localparam int ADDR_W = 32;
  // CPU data word width
  localparam int WORD_W = 32;
  // One byte select per byte lane of a word
  localparam int SEL_W = WORD_W / 8;

  // Byte address
  typedef logic [ADDR_W-1:0] addr_t;
  // CPU data word
  typedef logic [WORD_W-1:0] word_t;
  // Byte-select vector, bit n enables byte lane n
  typedef logic [SEL_W-1:0] sel_t;

  // ====================
  // Default geometry
  // ====================

  // Line size in bits, holds LINE_BITS/WORD_W words
  localparam int DEF_LINE_BITS = 128;
  // Associativity, a power of two and at least 2 for the PLRU tree
  localparam int DEF_NUM_WAYS = 4;
  // Number of sets, a power of two
  localparam int DEF_NUM_SETS = 8;

  // Default capacity in bytes, for reference only
  // 128 bits x 4 ways x 8 sets = 512 bytes

endpackage

`default_nettype wire
